//--- Bender.yml
package:
  name: cpu_control

sources:
  - logic/useq_pkg.sv
  - logic/upc_counter.sv
  - logic/control_store.sv
  - logic/microcode_sequencer.sv
  - logic/front_panel_port.sv
  - logic/cpu_control_top.sv
  - target: simulation
    files:
      - sim/cpu_control_assertions.sv
      - sim/tb_cpu_control.sv

//--- all.f
logic/useq_pkg.sv
logic/upc_counter.sv
logic/control_store.sv
logic/microcode_sequencer.sv
logic/front_panel_port.sv
logic/cpu_control_top.sv
sim/cpu_control_assertions.sv
sim/tb_cpu_control.sv

//--- logic/control_store.sv
/*
 * writable control store
 * 2^18 words of 24-bit microcode, read combinationally by the
 * sequencer and loaded one word per clock from the front panel
 */
`timescale 1ns/1ps
`default_nettype none

module control_store import useq_pkg::*; (
   input  logic                clk,
   // live micro-address from the sequencer
   input  uaddr_t              rd_addr,
   output ucontrol_t           rd_data,
   // load port from the front panel
   input  logic                we_store,
   input  logic [uaddr_w-1:0]  store_addr,
   input  ucontrol_t           store_data
);

   localparam int depth = 1 << uaddr_w;

   ucontrol_t mem [depth];

   // store starts out empty, every word a no-op
   initial begin
      for (int i = 0; i < depth; i++) begin
         mem[i] = '0;
      end
   end

   // control word follows the address in the same cycle
   assign rd_data = mem[rd_addr];

   // one word written per clock
   always @(posedge clk) begin
      if (we_store) begin
         mem[store_addr] <= store_data;
      end
   end

endmodule

`default_nettype wire

//--- logic/cpu_control_top.sv
/*
 * processor control unit
 * microcode sequencer together with its front panel loading
 * and readback port
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_control_top import useq_pkg::*; (
   input  logic                clk,
   input  logic                arst_n,
   // processor side
   input  logic                rst_hold,
   input  logic                irq_suc,
   input  logic [8:0]          ir_hi,
   input  logic                cond_in,
   input  logic [1:0]          idx,
   input  logic                halt_req,
   input  logic                end_ext,
   input  logic                wait_state,
   output logic [4:0]          raddr,
   output logic [4:0]          waddr,
   output logic [4:0]          cond,
   output logic [3:0]          action,
   output bus_strobes_t        strobes,
   output logic                uend,
   output logic                fetch,
   output logic                halted,
   // front panel wishbone
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  logic [wb_adr_w-1:0] wb_adr,
   input  logic [wb_dat_w-1:0] wb_dat_i,
   output logic [wb_dat_w-1:0] wb_dat_o,
   output logic                wb_ack
);

   // store load path
   logic               we_store;
   logic [uaddr_w-1:0] store_addr;
   ucontrol_t          store_data;
   // live state for the panel
   uaddr_t             uaddr;
   ucontrol_t          ucontrol;

   microcode_sequencer u_seq (
      .clk        (clk),
      .arst_n     (arst_n),
      .rst_hold   (rst_hold),
      .irq_suc    (irq_suc),
      .ir_hi      (ir_hi),
      .cond_in    (cond_in),
      .idx        (idx),
      .halt_req   (halt_req),
      .end_ext    (end_ext),
      .wait_state (wait_state),
      .we_store   (we_store),
      .store_addr (store_addr),
      .store_data (store_data),
      .raddr      (raddr),
      .waddr      (waddr),
      .cond       (cond),
      .action     (action),
      .strobes    (strobes),
      .uend       (uend),
      .fetch      (fetch),
      .halted     (halted),
      .uaddr      (uaddr),
      .ucontrol   (ucontrol)
   );

   front_panel_port u_panel (
      .clk        (clk),
      .arst_n     (arst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_i   (wb_dat_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack     (wb_ack),
      .we_store   (we_store),
      .store_addr (store_addr),
      .store_data (store_data),
      .uaddr      (uaddr),
      .ucontrol   (ucontrol),
      .fetch      (fetch),
      .halted     (halted)
   );

endmodule

`default_nettype wire

//--- logic/front_panel_port.sv
/*
 * front panel port
 * wishbone classic slave that loads microcode through an
 * auto-incrementing pointer and reads back the live micro-address,
 * control word and fetch/halt state
 */
`timescale 1ns/1ps
`default_nettype none

module front_panel_port import useq_pkg::*; (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  logic [wb_adr_w-1:0] wb_adr,
   input  logic [wb_dat_w-1:0] wb_dat_i,
   output logic [wb_dat_w-1:0] wb_dat_o,
   output logic                wb_ack,
   output logic                we_store,
   output logic [uaddr_w-1:0]  store_addr,
   output ucontrol_t           store_data,
   input  uaddr_t              uaddr,
   input  ucontrol_t           ucontrol,
   input  logic                fetch,
   input  logic                halted
);

   logic               req;
   logic               wr;
   logic [uaddr_w-1:0] load_ptr;

   ////////////////////////////////////////////////////////////////////////////
   // handshake and load pointer
   ////////////////////////////////////////////////////////////////////////////

   // new request, ack not yet given
   assign req = wb_cyc & wb_stb & ~wb_ack;
   assign wr  = req & wb_we;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack   <= 1'b0;
         load_ptr <= '0;
      end else begin
         // single cycle ack
         wb_ack <= req;
         if (wr && wb_adr == reg_load_addr) begin
            load_ptr <= wb_dat_i[uaddr_w-1:0];
         end else if (wr && wb_adr == reg_load_data) begin
            // step to the next word after each store
            load_ptr <= load_ptr + 1'b1;
         end
      end
   end

   // store write lands on the same edge that raises ack
   assign we_store   = wr && (wb_adr == reg_load_data);
   assign store_addr = load_ptr;

   // incoming word split into panel lanes
   always_comb begin
      store_data.lane[0] = wb_dat_i[7:0];
      store_data.lane[1] = wb_dat_i[15:8];
      store_data.lane[2] = wb_dat_i[23:16];
   end

   ////////////////////////////////////////////////////////////////////////////
   // readback
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (wb_adr)
         reg_load_addr: wb_dat_o = {{(wb_dat_w-uaddr_w){1'b0}}, load_ptr};
         reg_uaddr:     wb_dat_o = {{(wb_dat_w-uaddr_w){1'b0}}, uaddr};
         // lanes 2..0, top byte zero
         reg_ucontrol:  wb_dat_o = {8'h00, ucontrol.lane[2], ucontrol.lane[1],
                                    ucontrol.lane[0]};
         reg_status:    wb_dat_o = {{(wb_dat_w-2){1'b0}}, halted, fetch};
         // load data is write-only
         default:       wb_dat_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/microcode_sequencer.sv
/*
 * microcode sequencer
 * synchronizes halt, builds the micro-address, reads the control
 * store and splits the control word into its fields, holding the
 * bus strobes off during reset hold and halt
 */
`timescale 1ns/1ps
`default_nettype none

module microcode_sequencer import useq_pkg::*; (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                rst_hold,
   input  logic                irq_suc,
   input  logic [8:0]          ir_hi,
   input  logic                cond_in,
   input  logic [1:0]          idx,
   input  logic                halt_req,
   input  logic                end_ext,
   input  logic                wait_state,
   input  logic                we_store,
   input  logic [uaddr_w-1:0]  store_addr,
   input  ucontrol_t           store_data,
   output logic [4:0]          raddr,
   output logic [4:0]          waddr,
   output logic [4:0]          cond,
   output logic [3:0]          action,
   output bus_strobes_t        strobes,
   output logic                uend,
   output logic                fetch,
   output logic                halted,
   output uaddr_t              uaddr,
   output ucontrol_t           ucontrol
);

   logic             halt_meta;
   logic [upc_w-1:0] upc;
   logic             blank;

   ////////////////////////////////////////////////////////////////////////////
   // halt synchronizer
   ////////////////////////////////////////////////////////////////////////////

   // halt_req is asynchronous, two flops before it is used
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halt_meta <= 1'b0;
         halted    <= 1'b0;
      end else begin
         halt_meta <= halt_req;
         halted    <= halt_meta;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // micro-address and control store
   ////////////////////////////////////////////////////////////////////////////

   upc_counter u_upc (
      .clk        (clk),
      .arst_n     (arst_n),
      .halted     (halted),
      .uend       (ucontrol.fields.uend),
      .end_ext    (end_ext),
      .wait_state (wait_state),
      .upc        (upc)
   );

   // state bits on top, instruction opcode, flags, then the step
   always_comb begin
      uaddr.rst_hold = rst_hold;
      uaddr.irq_suc  = irq_suc;
      uaddr.ir_hi    = ir_hi;
      uaddr.cond_in  = cond_in;
      uaddr.idx      = idx;
      uaddr.upc      = upc;
   end

   control_store u_store (
      .clk        (clk),
      .rd_addr    (uaddr),
      .rd_data    (ucontrol),
      .we_store   (we_store),
      .store_addr (store_addr),
      .store_data (store_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // decode and strobe interlock
   ////////////////////////////////////////////////////////////////////////////

   // register and ALU selects always show the stored word
   assign raddr  = ucontrol.fields.raddr;
   assign waddr  = ucontrol.fields.waddr;
   assign cond   = ucontrol.fields.cond;
   assign action = ucontrol.fields.action;

   // no bus side effects during reset hold or while halted
   assign blank = rst_hold | halted;

   always_comb begin
      strobes.mem = ucontrol.fields.mem & ~blank;
      strobes.io  = ucontrol.fields.io  & ~blank;
      strobes.rd  = ucontrol.fields.rd  & ~blank;
      strobes.wen = ucontrol.fields.wen & ~blank;
   end

   assign uend = ucontrol.fields.uend & ~blank;

   // fetch covers the first micro-steps of every instruction
   assign fetch = (upc < fetch_upc);

endmodule

`default_nettype wire

//--- logic/upc_counter.sv
/*
 * microprogram counter
 * steps through the micro-instructions of one machine instruction,
 * restarting on end of instruction and stalling on wait or halt
 */
`timescale 1ns/1ps
`default_nettype none

module upc_counter import useq_pkg::*; (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             halted,
   // raw end field straight from the store, not blanked
   input  logic             uend,
   input  logic             end_ext,
   input  logic             wait_state,
   output logic [upc_w-1:0] upc
);

   logic [upc_w-1:0] upc_next;

   // priority is halt, then end, then wait, then count
   always_comb begin
      if (halted) begin
         // frozen, resumes from the same step
         upc_next = upc;
      end else if (uend || end_ext) begin
         // next instruction starts at step 0
         upc_next = '0;
      end else if (wait_state) begin
         // slow device holding the bus
         upc_next = upc;
      end else begin
         upc_next = upc + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         upc <= '0;
      end else begin
         upc <= upc_next;
      end
   end

endmodule

`default_nettype wire

//--- logic/useq_pkg.sv
/*
 * microcode sequencer shared definitions
 * field widths, front panel register map, micro-address layout
 * and the control word seen both as decoded fields and as
 * front panel byte lanes
 */
`default_nettype none

package useq_pkg;

   // widths fixed by the micro-address and control word layouts
   localparam int uaddr_w    = 18;
   localparam int ucontrol_w = 24;
   localparam int upc_w      = 4;

   // fetch is still running while upc sits below this step
   localparam logic [upc_w-1:0] fetch_upc = 4'd2;

   // wishbone geometry, word addressed
   localparam int wb_adr_w = 3;
   localparam int wb_dat_w = 32;

   // front panel register map
   localparam logic [wb_adr_w-1:0] reg_load_addr = 3'd0;
   localparam logic [wb_adr_w-1:0] reg_load_data = 3'd1;
   localparam logic [wb_adr_w-1:0] reg_uaddr     = 3'd2;
   localparam logic [wb_adr_w-1:0] reg_ucontrol  = 3'd3;
   localparam logic [wb_adr_w-1:0] reg_status    = 3'd4;

   // micro-address vector, msb first
   typedef struct packed {
      logic       rst_hold;
      logic       irq_suc;
      logic [8:0] ir_hi;
      logic       cond_in;
      logic [1:0] idx;
      logic [3:0] upc;
   } uaddr_t;

   // micro-control vector, msb first
   typedef struct packed {
      logic       uend;
      logic       wen;
      logic       rd;
      logic       io;
      logic       mem;
      logic [3:0] action;
      logic [4:0] cond;
      logic [4:0] waddr;
      logic [4:0] raddr;
   } ucontrol_fields_t;

   // same word as three panel lanes, lane 0 holds bits 7..0
   typedef union packed {
      ucontrol_fields_t  fields;
      logic [2:0][7:0]   lane;
   } ucontrol_t;

   // bus transaction strobes, active high
   typedef struct packed {
      logic mem;
      logic io;
      logic rd;
      logic wen;
   } bus_strobes_t;

endpackage

`default_nettype wire

//--- sim/cpu_control_assertions.sv
/*
 * concurrent checks on the processor control unit
 * wishbone ack width, bus strobe interlock and upc restart
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_control_assertions import useq_pkg::*; (
   input logic         clk,
   input logic         arst_n,
   input logic         wb_ack,
   input logic         rst_hold,
   input logic         halted,
   input logic         uend,
   input bus_strobes_t strobes,
   input uaddr_t       uaddr,
   input ucontrol_t    ucontrol
);

   // failed assertions so far
   int fail_count = 0;

   // ack is a one cycle pulse
   ack_single: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else begin
         fail_count++;
         $error("wishbone ack held for more than one cycle");
      end

   // no bus activity during reset hold or halt
   strobe_blank: assert property (@(posedge clk) disable iff (!arst_n)
      (rst_hold || halted) |-> (strobes == '0 && !uend))
      else begin
         fail_count++;
         $error("bus strobe or uend active under reset hold or halt");
      end

   // raw end field restarts the step counter
   upc_restart: assert property (@(posedge clk) disable iff (!arst_n)
      (ucontrol.fields.uend && !halted) |=> (uaddr.upc == '0))
      else begin
         fail_count++;
         $error("upc did not return to step 0 after end of instruction");
      end

endmodule

bind cpu_control_top cpu_control_assertions u_assertions (
   .clk      (clk),
   .arst_n   (arst_n),
   .wb_ack   (wb_ack),
   .rst_hold (rst_hold),
   .halted   (halted),
   .uend     (uend),
   .strobes  (strobes),
   .uaddr    (uaddr),
   .ucontrol (ucontrol)
);

`default_nettype wire

//--- sim/tb_cpu_control.sv
/*
 * testbench for the processor control unit
 * loads microcode over the front panel, walks a table of wait,
 * end and halt settings through a four step program and checks
 * the decode, fetch and halt outputs against a store model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_control import useq_pkg::*; ();

   localparam int wait_limit = 32;

   // one sequencer cycle with its inputs and the state expected after the edge
   typedef struct packed {
      logic       halt_req;
      logic       wait_state;
      logic       end_ext;
      logic [3:0] upc;
      logic       halted;
   } step_row_t;

   logic                clk;
   logic                arst_n;
   logic                rst_hold;
   logic                irq_suc;
   logic [8:0]          ir_hi;
   logic                cond_in;
   logic [1:0]          idx;
   logic                halt_req;
   logic                end_ext;
   logic                wait_state;
   logic [4:0]          raddr;
   logic [4:0]          waddr;
   logic [4:0]          cond;
   logic [3:0]          action;
   bus_strobes_t        strobes;
   logic                uend;
   logic                fetch;
   logic                halted;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [wb_adr_w-1:0] wb_adr;
   logic [wb_dat_w-1:0] wb_dat_i;
   logic [wb_dat_w-1:0] wb_dat_o;
   logic                wb_ack;

   // store model filled by the write task
   logic [ucontrol_w-1:0] model_mem [logic [uaddr_w-1:0]];
   logic [uaddr_w-1:0]    model_ptr;
   step_row_t             rows [21];
   integer                seed;
   int                    error_count;

   cpu_control_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic uaddr_t make_uaddr(input logic hold, input logic suc,
                                         input logic [8:0] ir, input logic cin,
                                         input logic [1:0] ix, input logic [3:0] step);
      uaddr_t a;
      a.rst_hold = hold;
      a.irq_suc  = suc;
      a.ir_hi    = ir;
      a.cond_in  = cin;
      a.idx      = ix;
      a.upc      = step;
      return a;
   endfunction

   function automatic ucontrol_t make_word(input logic e, input logic w, input logic r,
                                           input logic i, input logic m,
                                           input logic [3:0] act, input logic [4:0] cnd,
                                           input logic [4:0] wa, input logic [4:0] ra);
      ucontrol_t c;
      c.fields.uend   = e;
      c.fields.wen    = w;
      c.fields.rd     = r;
      c.fields.io     = i;
      c.fields.mem    = m;
      c.fields.action = act;
      c.fields.cond   = cnd;
      c.fields.waddr  = wa;
      c.fields.raddr  = ra;
      return c;
   endfunction

   // unwritten words read back as zero
   function automatic ucontrol_t stored_word(input uaddr_t a);
      if (model_mem.exists(a)) begin
         return model_mem[a];
      end
      return '0;
   endfunction

   // strobes and uend drop out under hold or halt while the selects stay
   function automatic ucontrol_t shown_word(input ucontrol_t w, input logic blank);
      ucontrol_t v;
      v = w;
      if (blank) begin
         v.fields.uend = 1'b0;
         v.fields.wen  = 1'b0;
         v.fields.rd   = 1'b0;
         v.fields.io   = 1'b0;
         v.fields.mem  = 1'b0;
      end
      return v;
   endfunction

   // decoded outputs gathered back into the control word layout
   function automatic ucontrol_t pin_view();
      ucontrol_t v;
      v.fields.uend   = uend;
      v.fields.wen    = strobes.wen;
      v.fields.rd     = strobes.rd;
      v.fields.io     = strobes.io;
      v.fields.mem    = strobes.mem;
      v.fields.action = action;
      v.fields.cond   = cond;
      v.fields.waddr  = waddr;
      v.fields.raddr  = raddr;
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic abort(input string line);
      error_count++;
      $display("%s", line);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_ucontrol(input string what, input ucontrol_t got,
                                 input ucontrol_t exp);
      if (got !== exp) begin
         abort($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_strobes(input string what, input bus_strobes_t got,
                                input bus_strobes_t exp);
      if (got !== exp) begin
         abort($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_uaddr(input string what, input uaddr_t got, input uaddr_t exp);
      if (got !== exp) begin
         abort($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         abort($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         abort($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   // a failing bound assertion stops the run at the next falling edge
   always @(negedge clk) begin
      if (uut.u_assertions.fail_count != 0) begin
         abort("a bound assertion on the control unit failed");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // wishbone master and sequencer control
   ////////////////////////////////////////////////////////////////////////////

   task automatic wait_ack();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > wait_limit) begin
            abort("timeout: the front panel port never raised wishbone ack");
         end
      end while (wb_ack !== 1'b1);
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= adr;
      wb_dat_i <= data;
      wait_ack();
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      // pointer and store model follow the register map
      if (adr == reg_load_addr) begin
         model_ptr = data[uaddr_w-1:0];
      end else if (adr == reg_load_data) begin
         model_mem[model_ptr] = data[ucontrol_w-1:0];
         model_ptr++;
      end
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      wb_adr <= adr;
      wait_ack();
      // read data is valid in the ack cycle
      data = wb_dat_o;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic wait_halted(input logic level);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n > wait_limit) begin
            abort("timeout: halted never followed the halt request");
         end
      end while (halted !== level);
   endtask

   // external end plus halt leaves upc frozen at step 0
   task automatic park();
      @(posedge clk);
      halt_req   <= 1'b1;
      end_ext    <= 1'b1;
      wait_state <= 1'b0;
      wait_halted(1'b1);
      @(posedge clk);
      end_ext <= 1'b0;
   endtask

   // halt_req, wait, end, then expected upc and halted
   task automatic fill_table();
      // run 0..3 then restart on uend
      rows[0]  = '{1'b0, 1'b0, 1'b0, 4'd0, 1'b1};
      rows[1]  = '{1'b0, 1'b0, 1'b0, 4'd0, 1'b1};
      rows[2]  = '{1'b0, 1'b0, 1'b0, 4'd0, 1'b0};
      rows[3]  = '{1'b0, 1'b0, 1'b0, 4'd1, 1'b0};
      rows[4]  = '{1'b0, 1'b0, 1'b0, 4'd2, 1'b0};
      rows[5]  = '{1'b0, 1'b0, 1'b0, 4'd3, 1'b0};
      rows[6]  = '{1'b0, 1'b0, 1'b0, 4'd0, 1'b0};
      // wait holds the step
      rows[7]  = '{1'b0, 1'b1, 1'b0, 4'd1, 1'b0};
      rows[8]  = '{1'b0, 1'b1, 1'b0, 4'd1, 1'b0};
      rows[9]  = '{1'b0, 1'b0, 1'b0, 4'd1, 1'b0};
      // external end
      rows[10] = '{1'b0, 1'b0, 1'b1, 4'd2, 1'b0};
      rows[11] = '{1'b0, 1'b0, 1'b0, 4'd0, 1'b0};
      // halt lands two edges late and freezes on the uend step
      rows[12] = '{1'b1, 1'b0, 1'b0, 4'd1, 1'b0};
      rows[13] = '{1'b1, 1'b0, 1'b0, 4'd2, 1'b0};
      rows[14] = '{1'b1, 1'b0, 1'b0, 4'd3, 1'b1};
      rows[15] = '{1'b1, 1'b0, 1'b0, 4'd3, 1'b1};
      rows[16] = '{1'b0, 1'b0, 1'b0, 4'd3, 1'b1};
      rows[17] = '{1'b0, 1'b0, 1'b0, 4'd3, 1'b1};
      // after release the held step finishes
      rows[18] = '{1'b0, 1'b0, 1'b0, 4'd3, 1'b0};
      rows[19] = '{1'b0, 1'b0, 1'b0, 4'd0, 1'b0};
      rows[20] = '{1'b0, 1'b0, 1'b0, 4'd1, 1'b0};
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      ucontrol_t   prog [4];
      ucontrol_t   hold_word;
      uaddr_t      base;
      uaddr_t      exp_addr;
      logic [17:0] next_ptr;
      logic [31:0] rdata;
      logic [31:0] rnd;
      logic [8:0]  prog_ir;
      logic [1:0]  prog_idx;
      logic [8:0]  r_ir;
      logic [1:0]  r_idx;
      logic        r_suc;
      logic        r_cin;
      seed        = 32'hce42;
      error_count = 0;
      model_ptr   = '0;
      arst_n      = 1'b0;
      rst_hold    = 1'b0;
      irq_suc     = 1'b0;
      ir_hi       = '0;
      cond_in     = 1'b0;
      idx         = '0;
      halt_req    = 1'b0;
      end_ext     = 1'b0;
      wait_state  = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_i    = '0;
      fill_table();
      prog_ir  = 9'h0a5;
      prog_idx = 2'b01;
      // memory read, register write, io access, then end with everything on
      prog[0] = make_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 4'h3, 5'h01, 5'h02, 5'h03);
      prog[1] = make_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'h7, 5'h04, 5'h05, 5'h06);
      prog[2] = make_word(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 4'ha, 5'h11, 5'h12, 5'h13);
      prog[3] = make_word(1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 4'hf, 5'h1f, 5'h1e, 5'h1d);
      repeat (10) @(posedge clk);
      arst_n  <= 1'b1;
      ir_hi   <= prog_ir;
      idx     <= prog_idx;

      // load the program and check the pointer moved past it
      base = make_uaddr(1'b0, 1'b0, prog_ir, 1'b0, prog_idx, 4'd0);
      wb_write(reg_load_addr, {14'd0, base});
      for (int k = 0; k < 4; k++) begin
         wb_write(reg_load_data, {8'h00, prog[k]});
      end
      next_ptr = base + 18'd4;
      wb_read(reg_load_addr, rdata);
      check_word("load pointer", rdata, {14'd0, next_ptr});

      // step through the program on wait and read each word back
      park();
      @(posedge clk);
      wait_state <= 1'b1;
      halt_req   <= 1'b0;
      wait_halted(1'b0);
      for (int k = 0; k < 3; k++) begin
         exp_addr = make_uaddr(1'b0, 1'b0, prog_ir, 1'b0, prog_idx, k[3:0]);
         wb_read(reg_ucontrol, rdata);
         check_word("panel control word", rdata, {8'h00, prog[k]});
         wb_read(reg_uaddr, rdata);
         check_word("panel micro-address", rdata, {14'd0, exp_addr});
         wb_read(reg_status, rdata);
         check_word("panel status", rdata, {30'd0, 1'b0, (k < fetch_upc)});
         @(posedge clk);
         wait_state <= 1'b0;
         @(posedge clk);
         wait_state <= 1'b1;
      end

      // sequencing, wait, external end and halt from the table
      park();
      for (int i = 0; i < 21; i++) begin
         @(posedge clk);
         halt_req   <= rows[i].halt_req;
         wait_state <= rows[i].wait_state;
         end_ext    <= rows[i].end_ext;
         @(negedge clk);
         exp_addr = make_uaddr(1'b0, 1'b0, prog_ir, 1'b0, prog_idx, rows[i].upc);
         check_uaddr($sformatf("row %0d micro-address", i), uut.uaddr, exp_addr);
         check_flag($sformatf("row %0d halted", i), halted, rows[i].halted);
         check_flag($sformatf("row %0d fetch", i), fetch, rows[i].upc < fetch_upc);
         check_ucontrol($sformatf("row %0d decoded fields", i), pin_view(),
                        shown_word(stored_word(exp_addr), rows[i].halted));
      end

      // reset hold with random address fields where every step ends at once
      for (int t = 0; t < 4; t++) begin
         rnd   = $random(seed);
         r_ir  = rnd[8:0];
         r_idx = rnd[10:9];
         r_suc = rnd[11];
         r_cin = rnd[12];
         rnd   = $random(seed);
         hold_word = rnd[23:0];
         hold_word.fields.uend = 1'b1;
         hold_word.fields.wen  = 1'b1;
         hold_word.fields.rd   = 1'b1;
         hold_word.fields.io   = 1'b1;
         hold_word.fields.mem  = 1'b1;
         base = make_uaddr(1'b1, r_suc, r_ir, r_cin, r_idx, 4'd0);
         @(posedge clk);
         rst_hold <= 1'b1;
         irq_suc  <= r_suc;
         ir_hi    <= r_ir;
         cond_in  <= r_cin;
         idx      <= r_idx;
         wb_write(reg_load_addr, {14'd0, base});
         repeat (16) wb_write(reg_load_data, {8'h00, hold_word});
         next_ptr = base + 18'd16;
         wb_read(reg_load_addr, rdata);
         check_word("load pointer after hold words", rdata, {14'd0, next_ptr});
         wb_read(reg_uaddr, rdata);
         check_word("panel micro-address under hold", rdata, {14'd0, base});
         wb_read(reg_ucontrol, rdata);
         check_word("panel control word under hold", rdata, {8'h00, hold_word});
         @(negedge clk);
         check_strobes("strobes under hold", strobes, '0);
         check_flag("uend under hold", uend, 1'b0);
         check_ucontrol("fields under hold", pin_view(), shown_word(hold_word, 1'b1));
      end
      @(posedge clk);
      rst_hold <= 1'b0;
      @(posedge clk);

      if (error_count == 0 && uut.u_assertions.fail_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire
